/* logic/coreDefs_defs.svh */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// first fetch address out of reset.
`define RESET_PC 32'h8000_0000

// data and address width.
`define XLEN 32

// architectural register count and its index width.
`define REG_COUNT 32
`define REG_ADDR_W 5

// addi x0, x0, 0.
`define INST_NOP 32'h0000_0013

// the only opSystem encoding the core accepts.
`define INST_EBREAK 32'h0010_0073

`endif

/* logic/corePkg.sv */
package corePkg;

  // major opcodes of the supported RV32I subset.
  typedef enum logic [6:0] {
    opLoad   = 7'b0000011,
    opImm    = 7'b0010011,
    opAuipc  = 7'b0010111,
    opStore  = 7'b0100011,
    opReg    = 7'b0110011,
    opLui    = 7'b0110111,
    opJalr   = 7'b1100111,
    opJal    = 7'b1101111,
    opSystem = 7'b1110011
  } opcodeE;

  typedef enum logic [1:0] {
    aluAdd,
    aluSltu,
    aluAnd,
    aluPassB // lui passes the immediate through.
  } aluOpE;

  typedef enum logic [2:0] {
    immI,
    immS,
    immU,
    immJ
  } immTypeE;

  // source of the register writeback value.
  typedef enum logic [1:0] {
    wbMem,
    wbAlu,
    wbLink
  } wbSelE;

endpackage

/* logic/ctrlIf.sv */
`timescale 1ns/1ns

interface ctrlIf import corePkg::*; ();

  logic    regWrite;
  logic    pcSel;    // 1 takes the ALU target.
  logic    aluASel;  // 1 selects pc as operand A.
  logic    aluBSel;  // 1 selects the immediate as operand B.
  logic    memWrite;
  wbSelE   wbSel;
  aluOpE   aluOp;
  immTypeE immType;
  logic    halt;

  modport decoder (
    output regWrite, pcSel, aluASel, aluBSel, memWrite,
    output wbSel, aluOp, immType, halt
  );

  modport fetch (input pcSel, halt);

  modport exec (input aluASel, aluBSel, aluOp, wbSel);

  modport imm (input immType);

  modport regs (input regWrite, halt);

endinterface

/* logic/fetchUnit.sv */
`timescale 1ns/1ns
`include "coreDefs_defs.svh"

module fetchUnit (
  input  logic               clk,
  input  logic               arstN,
  ctrlIf.fetch               ctrl,
  input  logic [`XLEN-1:0]   aluOut,
  output logic [`XLEN-1:0]   pc,
  output logic [`XLEN-1:0]   linkPc
);

  logic [`XLEN-1:0] nextPc;

  assign linkPc = pc + `XLEN'd4; // sequential address.

  // jalr target has bit 0 cleared, jal targets are already even.
  always_comb begin
    if (ctrl.pcSel) begin
      nextPc = {aluOut[`XLEN-1:1], 1'b0};
    end else begin
      nextPc = linkPc;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc <= `RESET_PC;
    end else if (!ctrl.halt) begin // parked on ebreak.
      pc <= nextPc;
    end
  end

endmodule

/* logic/decoder.sv */
`timescale 1ns/1ns
`include "coreDefs_defs.svh"

module decoder import corePkg::*; (
  input  logic [`XLEN-1:0] inst,
  ctrlIf.decoder           ctrl
);

  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_AND  = 3'b111;

  opcodeE     opcode;
  logic [2:0] funct3;
  aluOpE      f3Op;
  logic       f3Ok;

  assign opcode = opcodeE'(inst[6:0]);
  assign funct3 = inst[14:12];

  // shared funct3 decode for opImm and opReg, no funct7 so add never becomes sub.
  always_comb begin
    f3Ok = 1'b1;
    case (funct3)
      F3_ADD:  f3Op = aluAdd;
      F3_SLTU: f3Op = aluSltu;
      F3_AND:  f3Op = aluAnd;
      default: begin
        f3Op = aluAdd;
        f3Ok = 1'b0; // unsupported, no write.
      end
    endcase
  end

  always_comb begin
    ctrl.regWrite = 1'b0;
    ctrl.pcSel    = 1'b0;
    ctrl.aluASel  = 1'b0;
    ctrl.aluBSel  = 1'b0;
    ctrl.memWrite = 1'b0;
    ctrl.wbSel    = wbAlu;
    ctrl.aluOp    = aluAdd;
    ctrl.immType  = immI;
    ctrl.halt     = 1'b0;
    case (opcode)
      opImm: begin
        ctrl.regWrite = f3Ok;
        ctrl.aluBSel  = 1'b1;
        ctrl.aluOp    = f3Op;
      end
      opReg: begin
        ctrl.regWrite = f3Ok;
        ctrl.aluOp    = f3Op;
      end
      opLui: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluBSel  = 1'b1;
        ctrl.aluOp    = aluPassB;
        ctrl.immType  = immU;
      end
      opAuipc: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluASel  = 1'b1;
        ctrl.aluBSel  = 1'b1;
        ctrl.immType  = immU;
      end
      opJal: begin
        ctrl.regWrite = 1'b1;
        ctrl.pcSel    = 1'b1;
        ctrl.aluASel  = 1'b1; // pc + offset.
        ctrl.aluBSel  = 1'b1;
        ctrl.immType  = immJ;
        ctrl.wbSel    = wbLink;
      end
      opJalr: begin
        ctrl.regWrite = 1'b1;
        ctrl.pcSel    = 1'b1;
        ctrl.aluBSel  = 1'b1;
        ctrl.wbSel    = wbLink;
      end
      opLoad: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluBSel  = 1'b1;
        ctrl.wbSel    = wbMem;
      end
      opStore: begin
        ctrl.memWrite = 1'b1;
        ctrl.aluBSel  = 1'b1;
        ctrl.immType  = immS;
      end
      opSystem: ctrl.halt = (inst == `INST_EBREAK); // no writes while halted.
      default: ;
    endcase
  end

endmodule

/* logic/immGen.sv */
`timescale 1ns/1ns
`include "coreDefs_defs.svh"

module immGen import corePkg::*; (
  input  logic [`XLEN-1:0] inst,
  ctrlIf.imm               ctrl,
  output logic [`XLEN-1:0] imm
);

  logic sign;

  assign sign = inst[31]; // all formats sign from bit 31.

  always_comb begin
    case (ctrl.immType)
      immI: begin
        imm = {{20{sign}}, inst[31:20]};
      end
      immS: begin
        imm = {{20{sign}}, inst[31:25], inst[11:7]};
      end
      immU: begin
        imm = {inst[31:12], 12'b0};
      end
      immJ: begin
        imm = {{12{sign}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      default: begin
        imm = '0;
      end
    endcase
  end

endmodule

/* logic/registerFile.sv */
`timescale 1ns/1ns
`include "coreDefs_defs.svh"

module registerFile (
  input  logic                   clk,
  input  logic                   arstN,
  ctrlIf.regs                    ctrl,
  input  logic [`REG_ADDR_W-1:0] rs1,
  input  logic [`REG_ADDR_W-1:0] rs2,
  input  logic [`REG_ADDR_W-1:0] rd,
  input  logic [`XLEN-1:0]       wdata,
  output logic [`XLEN-1:0]       rdata1,
  output logic [`XLEN-1:0]       rdata2
);

  logic [`XLEN-1:0] regs [`REG_COUNT];
  logic             wrEn;

  assign wrEn = ctrl.regWrite && (rd != '0); // x0 is never written.

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn) begin
      regs[rd] <= wdata;
    end
  end

  assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* logic/executeUnit.sv */
`timescale 1ns/1ns
`include "coreDefs_defs.svh"

module executeUnit import corePkg::*; (
  ctrlIf.exec              ctrl,
  input  logic [`XLEN-1:0] pc,
  input  logic [`XLEN-1:0] linkPc,
  input  logic [`XLEN-1:0] rdata1,
  input  logic [`XLEN-1:0] rdata2,
  input  logic [`XLEN-1:0] imm,
  input  logic [`XLEN-1:0] memDataR,
  output logic [`XLEN-1:0] aluOut,
  output logic [`XLEN-1:0] wbData,
  output logic [`XLEN-1:0] memAddr,
  output logic [`XLEN-1:0] memDataW
);

  logic [`XLEN-1:0] opA;
  logic [`XLEN-1:0] opB;

  assign opA = ctrl.aluASel ? pc : rdata1;
  assign opB = ctrl.aluBSel ? imm : rdata2;

  always_comb begin
    case (ctrl.aluOp)
      aluAdd:   aluOut = opA + opB;
      aluSltu:  aluOut = {{(`XLEN-1){1'b0}}, opA < opB}; // unsigned compare.
      aluAnd:   aluOut = opA & opB;
      aluPassB: aluOut = opB;
      default:  aluOut = '0;
    endcase
  end

  always_comb begin
    case (ctrl.wbSel)
      wbMem:   wbData = memDataR;
      wbAlu:   wbData = aluOut;
      wbLink:  wbData = linkPc; // return address for jal and jalr.
      default: wbData = aluOut;
    endcase
  end

  // word access only, address comes straight from the adder.
  assign memAddr  = aluOut;
  assign memDataW = rdata2;

endmodule

/* logic/singleCycleCore.sv */
`timescale 1ns/1ns
`include "coreDefs_defs.svh"

module singleCycleCore (
  input  logic             clk,
  input  logic             arstN,
  input  logic [`XLEN-1:0] inst,
  input  logic [`XLEN-1:0] memDataR,
  output logic [`XLEN-1:0] pc,
  output logic             memWrite,
  output logic [`XLEN-1:0] memAddr,
  output logic [`XLEN-1:0] memDataW,
  output logic             halt
);

  logic [`REG_ADDR_W-1:0] rs1;
  logic [`REG_ADDR_W-1:0] rs2;
  logic [`REG_ADDR_W-1:0] rd;
  logic [`XLEN-1:0]       imm;
  logic [`XLEN-1:0]       rdata1;
  logic [`XLEN-1:0]       rdata2;
  logic [`XLEN-1:0]       aluOut;
  logic [`XLEN-1:0]       wbData;
  logic [`XLEN-1:0]       linkPc;

  ctrlIf ctrlBus ();

  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];
  assign rd  = inst[11:7];

  assign memWrite = ctrlBus.memWrite;
  assign halt     = ctrlBus.halt;

  fetchUnit u_fetch (
    .clk    (clk),
    .arstN  (arstN),
    .ctrl   (ctrlBus.fetch),
    .aluOut (aluOut),
    .pc     (pc),
    .linkPc (linkPc)
  );

  decoder u_decoder (
    .inst (inst),
    .ctrl (ctrlBus.decoder)
  );

  immGen u_immGen (
    .inst (inst),
    .ctrl (ctrlBus.imm),
    .imm  (imm)
  );

  registerFile u_regs (
    .clk    (clk),
    .arstN  (arstN),
    .ctrl   (ctrlBus.regs),
    .rs1    (rs1),
    .rs2    (rs2),
    .rd     (rd),
    .wdata  (wbData),
    .rdata1 (rdata1),
    .rdata2 (rdata2)
  );

  executeUnit u_exec (
    .ctrl     (ctrlBus.exec),
    .pc       (pc),
    .linkPc   (linkPc),
    .rdata1   (rdata1),
    .rdata2   (rdata2),
    .imm      (imm),
    .memDataR (memDataR),
    .aluOut   (aluOut),
    .wbData   (wbData),
    .memAddr  (memAddr),
    .memDataW (memDataW)
  );

endmodule

/* testbench/clockGen.sv */
`timescale 1ns/1ns

module clockGen (
  output logic clk,
  output logic arstN
);

  initial begin
    clk   = 1'b0;
    arstN = 1'b0; // held in reset from time zero.
  end

  always #4 clk = ~clk; // 8 ns period.

  // two full cycles of reset, edges placed on the falling clock.
  task automatic applyReset();
    @(negedge clk);
    arstN = 1'b0;
    repeat (2) @(negedge clk);
    arstN = 1'b1;
  endtask

endmodule

/* testbench/singleCycleCoreTb.sv */
`timescale 1ns/1ns
`include "coreDefs_defs.svh"

module singleCycleCoreTb;

  logic        clk;
  logic        arstN;
  logic [31:0] inst;
  logic [31:0] memDataR;
  logic [31:0] pc;
  logic        memWrite;
  logic [31:0] memAddr;
  logic [31:0] memDataW;
  logic        halt;

  string       testName[$];
  int          progStart[$];
  int          progLen[$];
  int          dataStart[$];
  int          dataLen[$];
  int          storeStart[$];
  int          storeLen[$];
  logic [31:0] progWords[$];
  logic [31:0] dataAddrs[$];
  logic [31:0] dataVals[$];
  logic [31:0] expAddrs[$];
  logic [31:0] expVals[$];

  logic [31:0] imem [256];
  logic [31:0] dmem [logic [31:0]];
  logic [31:0] gotAddrs[$];
  logic [31:0] gotVals[$];

  int passCount = 0;
  int failCount = 0;
  int cycleCount = 0;
  int cycleLimit = 0;

  clockGen u_clkGen (
    .clk   (clk),
    .arstN (arstN)
  );

  singleCycleCore u_dut (
    .clk      (clk),
    .arstN    (arstN),
    .inst     (inst),
    .memDataR (memDataR),
    .pc       (pc),
    .memWrite (memWrite),
    .memAddr  (memAddr),
    .memDataW (memDataW),
    .halt     (halt)
  );

  // words past the program read as ebreak.
  function automatic logic [31:0] fetchWord(input logic [31:0] addr);
    logic [31:0] offset;
    offset = addr - `RESET_PC;
    if (offset[1:0] == 2'b00 && (offset >> 2) < 256) begin
      return imem[offset >> 2];
    end
    return `INST_EBREAK;
  endfunction

  function automatic logic [31:0] readData(input logic [31:0] addr);
    if (dmem.exists(addr)) begin
      return dmem[addr];
    end
    return addr ^ 32'h5a5a_c3c3; // unwritten words.
  endfunction

  // inst follows pc, then memDataR follows the address that inst produces.
  always @(negedge clk) begin
    #1;
    inst = arstN ? fetchWord(pc) : `INST_NOP;
    #1;
    memDataR = readData(memAddr);
  end

  always @(posedge clk) begin
    if (arstN && memWrite) begin
      gotAddrs.push_back(memAddr);
      gotVals.push_back(memDataW);
      dmem[memAddr] = memDataW;
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleLimit > 0 && cycleCount > cycleLimit) begin
      $display("Error: run stopped after %0d cycles without finishing", cycleCount);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic loadFile(output bit ok);
    int    fd;
    int    r;
    string kw;
    string name;
    string rest;
    logic [31:0] a;
    logic [31:0] v;
    ok = 1'b0;
    fd = $fopen("testbench/coreInput.txt", "r");
    if (fd == 0) begin
      $display("Error: cannot open testbench/coreInput.txt");
      return;
    end
    while (!$feof(fd)) begin
      r = $fscanf(fd, "%s", kw);
      if (r != 1) begin
        break;
      end
      if (kw == "#") begin
        r = $fgets(rest, fd);
      end else if (kw == "test") begin
        r = $fscanf(fd, "%s", name);
        testName.push_back(name);
        progStart.push_back(progWords.size());
        dataStart.push_back(dataAddrs.size());
        storeStart.push_back(expAddrs.size());
      end else if (kw == "prog") begin
        r = $fscanf(fd, "%h", v);
        progWords.push_back(v);
      end else if (kw == "data") begin
        r = $fscanf(fd, "%h %h", a, v);
        dataAddrs.push_back(a);
        dataVals.push_back(v);
      end else if (kw == "store") begin
        r = $fscanf(fd, "%h %h", a, v);
        expAddrs.push_back(a);
        expVals.push_back(v);
      end else if (kw == "end") begin
        progLen.push_back(progWords.size() - progStart[progStart.size()-1]);
        dataLen.push_back(dataAddrs.size() - dataStart[dataStart.size()-1]);
        storeLen.push_back(expAddrs.size() - storeStart[storeStart.size()-1]);
      end else begin
        $display("Error: unknown keyword %s in input file", kw);
        $fclose(fd);
        return;
      end
    end
    $fclose(fd);
    ok = (testName.size() > 0 && progLen.size() == testName.size());
    if (!ok) begin
      $display("Error: input file holds no complete test");
    end
  endtask

  task automatic checkStores(input int t, inout int errors);
    int n;
    int base;
    base = storeStart[t];
    n = (gotAddrs.size() > storeLen[t]) ? gotAddrs.size() : storeLen[t];
    for (int i = 0; i < n; i++) begin
      if (i >= gotAddrs.size()) begin
        $display("Error: store %0d to %h never happened", i, expAddrs[base+i]);
        errors++;
      end else if (i >= storeLen[t]) begin
        $display("Error: unexpected extra store %0d of %h to %h", i, gotVals[i], gotAddrs[i]);
        errors++;
      end else begin
        if (gotAddrs[i] !== expAddrs[base+i]) begin
          $display("Error memAddr store %0d: got %h expected %h",
                   i, gotAddrs[i], expAddrs[base+i]);
          errors++;
        end
        if (gotVals[i] !== expVals[base+i]) begin
          $display("Error memDataW store %0d: got %h expected %h",
                   i, gotVals[i], expVals[base+i]);
          errors++;
        end
      end
    end
  endtask

  task automatic runTest(input int t);
    int errors;
    errors = 0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = `INST_EBREAK;
    end
    for (int i = 0; i < progLen[t]; i++) begin
      imem[i] = progWords[progStart[t]+i];
    end
    dmem.delete();
    for (int i = 0; i < dataLen[t]; i++) begin
      dmem[dataAddrs[dataStart[t]+i]] = dataVals[dataStart[t]+i];
    end
    u_clkGen.applyReset();
    gotAddrs.delete();
    gotVals.delete();
    if (pc !== `RESET_PC) begin
      $display("Error pc after reset: got %h expected %h", pc, `RESET_PC);
      errors++;
    end
    do begin
      @(negedge clk);
      #3;
    end while (!halt);
    // parked on ebreak, nothing may move.
    repeat (4) begin
      @(negedge clk);
      #3;
      if (!halt) begin
        $display("Error: halt dropped after ebreak");
        errors++;
      end
    end
    checkStores(t, errors);
    if (errors == 0) begin
      passCount++;
      $display("test %s: ok", testName[t]);
    end else begin
      failCount++;
      $display("test %s: %0d errors", testName[t], errors);
    end
  endtask

  initial begin
    bit ok;
    int total;
    inst     = `INST_NOP;
    memDataR = '0;
    loadFile(ok);
    if (!ok) begin
      failCount++;
    end else begin
      total = 0;
      for (int t = 0; t < progLen.size(); t++) begin
        total += progLen[t];
      end
      cycleLimit = total * 4 + 100;
      for (int t = 0; t < testName.size(); t++) begin
        runTest(t);
      end
    end
    $display("passed %0d, failed %0d", passCount, failCount);
    if (failCount == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* testbench/coreInput.txt */
# test <name> / prog <word> / data <addr> <value> / store <addr> <value> / end
# words and addresses in hex, programs load at 80000000
test arith
prog 00500093 prog ffd00113 prog 002081b3 prog 0020b233 prog 0020f2b3
prog f9c10313 prog 001133b3 prog 10302023 prog 10402223 prog 10502423
prog 10602623 prog 10702823 prog 00100073
store 00000100 00000002 store 00000104 00000001 store 00000108 00000005
store 0000010c ffffff99 store 00000110 00000000
end
test upperImm
prog 123450b7 prog 00001117 prog fffff1b7 prog 10102023 prog 10202223
prog 10302423 prog 00100073
store 00000100 12345000 store 00000104 80001004 store 00000108 fffff000
end
test jumps
prog 00c000ef prog 1e002823 prog 1e002823 prog 10102023 prog 00000297
prog 00d28167 prog 1e002823 prog 10202223 prog 00100073
store 00000100 80000004 store 00000104 80000018
end
test memory
prog 05500093 prog 10102023 prog 10002103 prog 00110113 prog 10202223
prog 14002183 prog 00318233 prog 10402423 prog 00100073
data 00000140 00001234
store 00000100 00000055 store 00000104 00000056 store 00000108 00002468
end
test zeroReg
prog 04d00013 prog 10002023 prog 12345037 prog 10002223 prog 00100073
store 00000100 00000000 store 00000104 00000000
end
test haltStop
prog 00900093 prog 10102023 prog 00100073 prog 10102223
store 00000100 00000009
end
test resetClear
prog 10102023 prog 00100073
store 00000100 00000000
end

/* singleCycleCore.f */
+incdir+logic
logic/corePkg.sv
logic/ctrlIf.sv
logic/fetchUnit.sv
logic/decoder.sv
logic/immGen.sv
logic/registerFile.sv
logic/executeUnit.sv
logic/singleCycleCore.sv
testbench/clockGen.sv
testbench/singleCycleCoreTb.sv
